//--- Makefile
VERILATOR ?= verilator
TOP ?= powerOptimizerTb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
RUN_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
logic/powerPkg.sv
logic/powerEstimator.sv
logic/powerStateManager.sv
logic/dvfsController.sv
logic/gatingController.sv
logic/powerOptimizer.sv
verif/tbClock.sv
verif/powerOptimizer_props.sv
verif/powerOptimizerTb.sv

//--- logic/dvfsController.sv
`timescale 1ns/1ps
`default_nettype none

module dvfsController (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    classificationValid,
    input  wire powerPkg::workloadT workloadFormat,
    input  wire [3:0]              workloadConfidence,
    input  wire                    performanceMode,
    input  wire                    activeProcessor,
    input  wire powerPkg::powerT   currentTotalPower,
    input  wire powerPkg::powerT   powerBudget,
    input  wire powerPkg::powerT   temperatureEstimate,
    input  wire                    thermalThrottle,
    input  wire                    emergencyActive,
    output powerPkg::levelT        clockFrequencyLevel,
    output powerPkg::levelT        voltageLevel
);

    import powerPkg::*;

    localparam int timerWidth = $clog2(stepInterval);

    levelT                 level;
    levelT                 target;
    levelT                 workloadTarget;
    logic [timerWidth-1:0] stepTimer;
    logic [2:0]            holdoff;
    logic                  confident;
    logic                  overBudget;
    logic                  stepReady;
    logic                  raiseAllowed;

    always_comb begin
        case (workloadFormat)
            wlIdle:      workloadTarget = 3'd1;
            wlCompute:   workloadTarget = performanceMode ? 3'd6 : 3'd4;
            wlStreaming: workloadTarget = 3'd4;
            // Memory, mixed and the rest sit at the middle level
            default:     workloadTarget = 3'd3;
        endcase
    end

    always_comb begin
        confident = classificationValid && (workloadConfidence >= confidenceMin);
        overBudget = currentTotalPower > powerBudget;
        stepReady = (stepTimer == timerWidth'(stepInterval - 1)) && (holdoff == 3'd0);
        // An idle core gains nothing from a faster clock
        raiseAllowed = !thermalThrottle && activeProcessor;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            level <= resetLevel;
            target <= resetLevel;
            stepTimer <= '0;
            holdoff <= 3'd0;
        end else begin
            stepTimer <= stepTimer + timerWidth'(1);
            if (holdoff != 3'd0) begin
                holdoff <= holdoff - 3'd1;
            end

            if (emergencyActive) begin
                level <= 3'd0;
            end else begin
                // Budget pressure wins over the workload hint
                if (overBudget && level != 3'd0) begin
                    target <= level - 3'd1;
                end else if (confident) begin
                    target <= workloadTarget;
                end

                if (temperatureEstimate > thermalWarning && level > 3'd1) begin
                    level <= level - 3'd1;
                end else if (stepReady) begin
                    if (raiseAllowed && level < target) begin
                        level <= level + 3'd1;
                        holdoff <= stepHoldoff;
                    end else if (level > target) begin
                        level <= level - 3'd1;
                        holdoff <= stepHoldoff;
                    end
                end
            end
        end
    end

    // Voltage tracks frequency one to one
    assign clockFrequencyLevel = level;
    assign voltageLevel = level;

endmodule

`default_nettype wire

//--- logic/gatingController.sv
`timescale 1ns/1ps
`default_nettype none

module gatingController (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     classificationValid,
    input  wire powerPkg::workloadT workloadFormat,
    input  wire [3:0]               workloadConfidence,
    input  wire                     activeProcessor,
    input  wire powerPkg::powerT    currentTotalPower,
    input  wire powerPkg::powerT    powerBudget,
    input  wire                     emergencyActive,
    output logic                    powerGateALU,
    output logic                    powerGateBranchPredictor,
    output logic                    powerGateCache
);

    import powerPkg::*;

    logic confident;

    assign confident = classificationValid && (workloadConfidence >= confidenceMin);

    always_ff @(posedge clk) begin
        if (!reset) begin
            powerGateALU <= 1'b0;
            powerGateBranchPredictor <= 1'b0;
            powerGateCache <= 1'b0;
        end else if (emergencyActive) begin
            powerGateALU <= !activeProcessor;
            powerGateBranchPredictor <= 1'b1;
            powerGateCache <= 1'b1;
        end else begin
            if (confident) begin
                case (workloadFormat)
                    wlIdle: begin
                        if (!activeProcessor) begin
                            powerGateALU <= 1'b1;
                            powerGateBranchPredictor <= 1'b1;
                            powerGateCache <= 1'b1;
                        end
                    end
                    wlCompute, wlMixed: begin
                        powerGateALU <= 1'b0;
                        powerGateCache <= 1'b0;
                    end
                    wlMemory: begin
                        powerGateBranchPredictor <= 1'b0;
                        powerGateALU <= !activeProcessor;
                    end
                    wlStreaming: begin
                        powerGateCache <= 1'b0;
                        powerGateALU <= !activeProcessor;
                    end
                    default: begin
                    end
                endcase
            end

            // Over budget and idle overrides the workload rules
            if (currentTotalPower > powerBudget && !activeProcessor) begin
                powerGateALU <= 1'b1;
                powerGateCache <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/powerEstimator.sv
`timescale 1ns/1ps
`default_nettype none

module powerEstimator (
    input  wire                  clk,
    input  wire                  reset,
    input  wire powerPkg::powerT powerALU,
    input  wire powerPkg::powerT powerRegister,
    input  wire powerPkg::powerT powerBranchPredictor,
    input  wire powerPkg::powerT powerCache,
    input  wire powerPkg::powerT powerCore,
    input  wire powerPkg::powerStateT powerState,
    input  wire powerPkg::levelT clockFrequencyLevel,
    input  wire                  powerGateALU,
    input  wire                  powerGateBranchPredictor,
    input  wire                  powerGateCache,
    output powerPkg::powerT      currentTotalPower
);

    import powerPkg::*;

    logic [10:0] componentSum;
    logic [15:0] scaledProduct;
    logic [15:0] scaledValue;
    powerT       gateSaving;

    powerT sumStage;
    powerT overheadStage;
    powerT scaledStage;

    // Five 8-bit terms fit in 11 bits
    always_comb begin
        componentSum = 11'(powerALU) + 11'(powerRegister) + 11'(powerBranchPredictor)
                     + 11'(powerCache) + 11'(powerCore);
    end

    always_comb begin
        scaledProduct = 16'(overheadStage) * 16'(dvfsPercent[clockFrequencyLevel]);
        scaledValue = scaledProduct / 16'd100;
    end

    // Savings of all gated blocks taken off in one subtraction
    always_comb begin
        gateSaving = 8'd0;
        if (powerGateALU) begin
            gateSaving = gateSaving + aluSaving;
        end
        if (powerGateBranchPredictor) begin
            gateSaving = gateSaving + bpSaving;
        end
        if (powerGateCache) begin
            gateSaving = gateSaving + cacheSaving;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            sumStage <= resetPower;
            overheadStage <= resetPower;
            scaledStage <= resetPower;
            currentTotalPower <= resetPower;
        end else begin
            // Stage 1 component sum
            sumStage <= (componentSum > 11'd255) ? 8'hFF : componentSum[7:0];

            // Stage 2 state overhead
            overheadStage <= satAdd(sumStage, stateOverhead[powerState]);

            // Stage 3 frequency scaling
            scaledStage <= (scaledValue > 16'd255) ? 8'hFF : scaledValue[7:0];

            // Stage 4 gating savings
            currentTotalPower <= floorSub(scaledStage, gateSaving);
        end
    end

endmodule

`default_nettype wire

//--- logic/powerOptimizer.sv
`timescale 1ns/1ps
`default_nettype none

module powerOptimizer (
    input  wire                       clk,
    input  wire                       reset,
    input  wire powerPkg::powerT      powerALU,
    input  wire powerPkg::powerT      powerRegister,
    input  wire powerPkg::powerT      powerBranchPredictor,
    input  wire powerPkg::powerT      powerCache,
    input  wire powerPkg::powerT      powerCore,
    input  wire powerPkg::workloadT   workloadFormat,
    input  wire [3:0]                 workloadConfidence,
    input  wire                       classificationValid,
    input  wire                       activeProcessor,
    input  wire powerPkg::powerT      powerBudget,
    input  wire powerPkg::powerT      thermalReading,
    input  wire                       performanceMode,
    output wire powerPkg::powerT      currentTotalPower,
    output wire powerPkg::powerStateT powerState,
    output wire powerPkg::powerT      temperatureEstimate,
    output wire                       thermalThrottle,
    output wire powerPkg::levelT      clockFrequencyLevel,
    output wire powerPkg::levelT      voltageLevel,
    output wire                       powerGateALU,
    output wire                       powerGateBranchPredictor,
    output wire                       powerGateCache
);

    wire emergencyActive;

    powerEstimator powerEstimator_i (
        .clk                      (clk),
        .reset                    (reset),
        .powerALU                 (powerALU),
        .powerRegister            (powerRegister),
        .powerBranchPredictor     (powerBranchPredictor),
        .powerCache               (powerCache),
        .powerCore                (powerCore),
        .powerState               (powerState),
        .clockFrequencyLevel      (clockFrequencyLevel),
        .powerGateALU             (powerGateALU),
        .powerGateBranchPredictor (powerGateBranchPredictor),
        .powerGateCache           (powerGateCache),
        .currentTotalPower        (currentTotalPower)
    );

    powerStateManager powerStateManager_i (
        .clk                 (clk),
        .reset               (reset),
        .currentTotalPower   (currentTotalPower),
        .thermalReading      (thermalReading),
        .powerBudget         (powerBudget),
        .activeProcessor     (activeProcessor),
        .temperatureEstimate (temperatureEstimate),
        .thermalThrottle     (thermalThrottle),
        .emergencyActive     (emergencyActive),
        .powerState          (powerState)
    );

    dvfsController dvfsController_i (
        .clk                 (clk),
        .reset               (reset),
        .classificationValid (classificationValid),
        .workloadFormat      (workloadFormat),
        .workloadConfidence  (workloadConfidence),
        .performanceMode     (performanceMode),
        .activeProcessor     (activeProcessor),
        .currentTotalPower   (currentTotalPower),
        .powerBudget         (powerBudget),
        .temperatureEstimate (temperatureEstimate),
        .thermalThrottle     (thermalThrottle),
        .emergencyActive     (emergencyActive),
        .clockFrequencyLevel (clockFrequencyLevel),
        .voltageLevel        (voltageLevel)
    );

    gatingController gatingController_i (
        .clk                      (clk),
        .reset                    (reset),
        .classificationValid      (classificationValid),
        .workloadFormat           (workloadFormat),
        .workloadConfidence       (workloadConfidence),
        .activeProcessor          (activeProcessor),
        .currentTotalPower        (currentTotalPower),
        .powerBudget              (powerBudget),
        .emergencyActive          (emergencyActive),
        .powerGateALU             (powerGateALU),
        .powerGateBranchPredictor (powerGateBranchPredictor),
        .powerGateCache           (powerGateCache)
    );

endmodule

`default_nettype wire

//--- logic/powerPkg.sv
`default_nettype none

package powerPkg;

    typedef enum logic [2:0] {
        stateIdle        = 3'd0,
        stateLow         = 3'd1,
        stateBalanced    = 3'd2,
        statePerformance = 3'd3,
        stateBurst       = 3'd4,
        stateThermal     = 3'd5,
        stateCritical    = 3'd6
    } powerStateT;

    typedef enum logic [2:0] {
        wlUnknown   = 3'd0,
        wlCompute   = 3'd1,
        wlMemory    = 3'd2,
        wlControl   = 3'd3,
        wlMixed     = 3'd4,
        wlIdle      = 3'd5,
        wlStreaming = 3'd6,
        wlIrregular = 3'd7
    } workloadT;

    typedef logic [2:0] levelT;
    typedef logic [7:0] powerT;

    // Thermal and budget thresholds
    localparam powerT thermalWarning = 8'd150;
    localparam powerT thermalRelease = 8'd120;
    localparam powerT thermalCritical = 8'd180;
    localparam powerT budgetMargin = 8'd20;
    localparam logic [3:0] confidenceMin = 4'd6;

    localparam powerT lowBand = 8'd40;
    localparam powerT balancedBand = 8'd100;
    localparam powerT performanceBand = 8'd150;

    // Indexed by powerStateT, unused encodings take 20
    localparam powerT stateOverhead [0:7] = '{
        8'd5, 8'd10, 8'd15, 8'd25, 8'd35, 8'd20, 8'd20, 8'd20
    };

    // Percent of nominal power per DVFS level
    localparam logic [7:0] dvfsPercent [0:7] = '{
        8'd30, 8'd45, 8'd60, 8'd80, 8'd100, 8'd120, 8'd145, 8'd175
    };

    localparam powerT aluSaving = 8'd15;
    localparam powerT bpSaving = 8'd5;
    localparam powerT cacheSaving = 8'd12;

    localparam logic [3:0] emergencyHold = 4'd15;
    localparam int stepInterval = 8;
    localparam logic [2:0] stepHoldoff = 3'd4;
    localparam levelT resetLevel = 3'd3;

    localparam powerT tempBase = 8'd80;
    localparam powerT throttleRelief = 8'd20;
    localparam powerT resetPower = 8'd80;
    localparam powerT resetTemperature = 8'd100;

    function automatic powerT satAdd(input powerT a, input powerT b);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[8] ? 8'hFF : sum[7:0];
    endfunction

    function automatic powerT floorSub(input powerT a, input powerT b);
        return (a > b) ? a - b : 8'd0;
    endfunction

endpackage

`default_nettype wire

//--- logic/powerStateManager.sv
`timescale 1ns/1ps
`default_nettype none

module powerStateManager (
    input  wire                  clk,
    input  wire                  reset,
    input  wire powerPkg::powerT currentTotalPower,
    input  wire powerPkg::powerT thermalReading,
    input  wire powerPkg::powerT powerBudget,
    input  wire                  activeProcessor,
    output powerPkg::powerT      temperatureEstimate,
    output logic                 thermalThrottle,
    output logic                 emergencyActive,
    output powerPkg::powerStateT powerState
);

    import powerPkg::*;

    logic [9:0] tempSum;
    powerT      tempRaw;
    powerT      tempNext;
    powerT      budgetLimit;
    logic       trigger;
    logic [3:0] countdown;

    // Simple thermal model from power and the sensor
    always_comb begin
        tempSum = 10'(tempBase) + 10'(currentTotalPower / 8'd3) + 10'(thermalReading / 8'd4);
        tempRaw = (tempSum > 10'd255) ? 8'hFF : tempSum[7:0];
        if (thermalThrottle) begin
            tempNext = floorSub(tempRaw, throttleRelief);
        end else begin
            tempNext = tempRaw;
        end
    end

    always_comb begin
        budgetLimit = satAdd(powerBudget, budgetMargin);
        trigger = (temperatureEstimate > thermalCritical) || (currentTotalPower > budgetLimit);
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            temperatureEstimate <= resetTemperature;
            countdown <= 4'd0;
            emergencyActive <= 1'b0;
            thermalThrottle <= 1'b0;
        end else begin
            temperatureEstimate <= tempNext;

            // Every trigger restarts the hold
            if (trigger) begin
                countdown <= emergencyHold;
            end else if (countdown != 4'd0) begin
                countdown <= countdown - 4'd1;
            end
            emergencyActive <= (countdown != 4'd0);

            // Hysteresis between warning and release
            if (trigger || temperatureEstimate > thermalWarning) begin
                thermalThrottle <= 1'b1;
            end else if (!emergencyActive && temperatureEstimate < thermalRelease) begin
                thermalThrottle <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            powerState <= stateBalanced;
        end else if (emergencyActive) begin
            powerState <= stateCritical;
        end else if (!activeProcessor) begin
            powerState <= stateIdle;
        end else if (currentTotalPower < lowBand) begin
            powerState <= stateLow;
        end else if (currentTotalPower < balancedBand) begin
            powerState <= stateBalanced;
        end else if (currentTotalPower < performanceBand) begin
            powerState <= statePerformance;
        end else begin
            powerState <= stateBurst;
        end
    end

endmodule

`default_nettype wire

//--- verif/powerOptimizerTb.sv
`timescale 1ns/1ps
`default_nettype none

module powerOptimizerTb;

    import powerPkg::*;

    localparam int stimulusCycles = 4000;
    // Reset, last stretch overshoot, drain and a margin
    localparam int watchdogCycles = 8 + stimulusCycles + 40 + 20 + 200;

    wire        clk;
    wire        reset;
    powerT      powerALU;
    powerT      powerRegister;
    powerT      powerBranchPredictor;
    powerT      powerCache;
    powerT      powerCore;
    workloadT   workloadFormat;
    logic [3:0] workloadConfidence;
    logic       classificationValid;
    logic       activeProcessor;
    powerT      powerBudget;
    powerT      thermalReading;
    logic       performanceMode;
    wire powerT      currentTotalPower;
    wire powerStateT powerState;
    wire powerT      temperatureEstimate;
    wire             thermalThrottle;
    wire levelT      clockFrequencyLevel;
    wire levelT      voltageLevel;
    wire             powerGateALU;
    wire             powerGateBranchPredictor;
    wire             powerGateCache;

    int seed = 89;
    int cyclesDone;
    int stretch;

    tbClock tbClock_i (
        .clk   (clk),
        .reset (reset)
    );

    powerOptimizer powerOptimizer_i (.*);

    bind powerOptimizer powerOptimizerProps powerOptimizerProps_i (.*);

    function automatic int randomBelow(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    task automatic driveComponents(input int base, input int span);
        powerALU <= 8'(base + randomBelow(span));
        powerRegister <= 8'(base + randomBelow(span));
        powerBranchPredictor <= 8'(base + randomBelow(span));
        powerCache <= 8'(base + randomBelow(span));
        powerCore <= 8'(base + randomBelow(span));
    endtask

    task automatic drivePhase(input int kind);
        case (kind)
            0: begin
                // Quiet light load with a generous budget
                driveComponents(0, 20);
                activeProcessor <= 1'b1;
                powerBudget <= 8'(200 + randomBelow(56));
                thermalReading <= 8'(randomBelow(60));
            end
            1: begin
                driveComponents(5, 45);
                classificationValid <= 1'b1;
                workloadFormat <= workloadT'(randomBelow(8));
                workloadConfidence <= 4'(4 + randomBelow(12));
                performanceMode <= randomBelow(2) == 1;
                activeProcessor <= 1'b1;
                powerBudget <= 8'(120 + randomBelow(120));
                thermalReading <= 8'(randomBelow(120));
            end
            2: begin
                driveComponents(0, 15);
                classificationValid <= randomBelow(4) != 0;
                workloadFormat <= wlIdle;
                workloadConfidence <= 4'd12;
                activeProcessor <= 1'b0;
                powerBudget <= 8'(randomBelow(256));
            end
            default: begin
                // Hot and over budget to force an emergency
                driveComponents(30, 60);
                activeProcessor <= randomBelow(2) == 1;
                powerBudget <= 8'(randomBelow(80));
                thermalReading <= 8'(150 + randomBelow(106));
            end
        endcase
    endtask

    initial begin
        powerALU = 8'd10;
        powerRegister = 8'd10;
        powerBranchPredictor = 8'd10;
        powerCache = 8'd10;
        powerCore = 8'd10;
        workloadFormat = wlUnknown;
        workloadConfidence = 4'd0;
        classificationValid = 1'b0;
        activeProcessor = 1'b1;
        powerBudget = 8'd200;
        thermalReading = 8'd40;
        performanceMode = 1'b0;
        wait (reset === 1'b1);
        cyclesDone = 0;
        while (cyclesDone < stimulusCycles) begin
            @(posedge clk);
            drivePhase(randomBelow(4));
            stretch = 1 + randomBelow(40);
            repeat (stretch - 1) @(posedge clk);
            cyclesDone += stretch;
        end
        repeat (20) @(posedge clk);
        // Let the checks of the last edge settle
        @(negedge clk);
        if (powerOptimizer_i.powerOptimizerProps_i.failCount == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "property checker reported %0d failures",
                   powerOptimizer_i.powerOptimizerProps_i.failCount);
        end
    end

    // Stop at the first failed assertion
    always @(posedge clk) begin
        if (powerOptimizer_i.powerOptimizerProps_i.failCount != 0) begin
            $display("Test failures found");
            $fatal(1, "an assertion in the property checker failed");
        end
    end

    initial begin
        #(watchdogCycles * 100);
        $display("Test failures found");
        $fatal(1, "Timeout: stimulus did not finish within %0d cycles", watchdogCycles);
    end

endmodule

`default_nettype wire

//--- verif/powerOptimizer_props.sv
`timescale 1ns/1ps
`default_nettype none

module powerOptimizerProps (
    input wire                       clk,
    input wire                       reset,
    input wire powerPkg::powerT      powerALU,
    input wire powerPkg::powerT      powerRegister,
    input wire powerPkg::powerT      powerBranchPredictor,
    input wire powerPkg::powerT      powerCache,
    input wire powerPkg::powerT      powerCore,
    input wire powerPkg::workloadT   workloadFormat,
    input wire [3:0]                 workloadConfidence,
    input wire                       classificationValid,
    input wire                       activeProcessor,
    input wire powerPkg::powerT      powerBudget,
    input wire powerPkg::powerT      thermalReading,
    input wire powerPkg::powerT      currentTotalPower,
    input wire powerPkg::powerStateT powerState,
    input wire powerPkg::powerT      temperatureEstimate,
    input wire                       thermalThrottle,
    input wire powerPkg::levelT      clockFrequencyLevel,
    input wire powerPkg::levelT      voltageLevel,
    input wire                       powerGateALU,
    input wire                       powerGateBranchPredictor,
    input wire                       powerGateCache,
    input wire                       emergencyActive
);

    import powerPkg::*;

    int               failCount = 0;
    logic [3:0]       sinceReset;
    logic [4:0]       triggerAge;
    logic [3:0][10:0] sumPipe;
    logic [2:0][2:0]  statePipe;
    logic [1:0][2:0]  levelPipe;
    int               savingPrev;
    int               expectedPower;
    int               tempModel;
    int               expectedTemp;
    int               budgetLimit;
    int               levelRise;
    powerStateT       stateModel;
    powerStateT       expectedState;
    levelT            prevLevel;
    logic             prevThrottle;
    logic             prevEmergency;
    logic             computeHeld;
    logic             trigger;

    always_comb begin
        budgetLimit = int'(powerBudget) + int'(budgetMargin);
        budgetLimit = (budgetLimit > 255) ? 255 : budgetLimit;
        trigger = (temperatureEstimate > thermalCritical)
                  || (int'(currentTotalPower) > budgetLimit);

        tempModel = int'(tempBase) + int'(currentTotalPower) / 3 + int'(thermalReading) / 4;
        tempModel = (tempModel > 255) ? 255 : tempModel;
        if (thermalThrottle) begin
            tempModel = (tempModel > int'(throttleRelief)) ? tempModel - int'(throttleRelief) : 0;
        end

        stateModel = emergencyActive ? stateCritical
                   : !activeProcessor ? stateIdle
                   : (currentTotalPower < lowBand) ? stateLow
                   : (currentTotalPower < balancedBand) ? stateBalanced
                   : (currentTotalPower < performanceBand) ? statePerformance
                   : stateBurst;

        // Four-stage estimate from the delayed inputs
        expectedPower = (sumPipe[3] > 11'd255) ? 255 : int'(sumPipe[3]);
        expectedPower = expectedPower + int'(stateOverhead[statePipe[2]]);
        expectedPower = (expectedPower > 255) ? 255 : expectedPower;
        expectedPower = expectedPower * int'(dvfsPercent[levelPipe[1]]) / 100;
        expectedPower = (expectedPower > 255) ? 255 : expectedPower;
        expectedPower = (expectedPower > savingPrev) ? expectedPower - savingPrev : 0;

        levelRise = int'(clockFrequencyLevel) - int'(prevLevel);
    end

    always_ff @(posedge clk) begin
        sumPipe <= {sumPipe[2:0], 11'(powerALU) + 11'(powerRegister)
                    + 11'(powerBranchPredictor) + 11'(powerCache) + 11'(powerCore)};
        statePipe <= {statePipe[1:0], powerState};
        levelPipe <= {levelPipe[0], clockFrequencyLevel};
        savingPrev <= (powerGateALU ? int'(aluSaving) : 0)
                      + (powerGateBranchPredictor ? int'(bpSaving) : 0)
                      + (powerGateCache ? int'(cacheSaving) : 0);
        expectedTemp <= tempModel;
        expectedState <= stateModel;
        prevLevel <= clockFrequencyLevel;
        prevThrottle <= thermalThrottle;
        prevEmergency <= emergencyActive;
        // Confident compute, no emergency, no idle over-budget override
        computeHeld <= !emergencyActive && classificationValid
                       && (workloadConfidence >= confidenceMin) && (workloadFormat == wlCompute)
                       && !((currentTotalPower > powerBudget) && !activeProcessor);
    end

    // Cycles since reset release and since the last emergency trigger
    always_ff @(posedge clk) begin
        if (!reset) begin
            sinceReset <= 4'd0;
            triggerAge <= 5'd0;
        end else begin
            if (sinceReset != 4'd15) begin
                sinceReset <= sinceReset + 4'd1;
            end
            if (trigger) begin
                triggerAge <= 5'd1;
            end else if (triggerAge != 5'd0 && triggerAge != 5'd31) begin
                triggerAge <= triggerAge + 5'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!reset)
        sinceReset == 4'd0 |-> currentTotalPower == 8'd80 && temperatureEstimate == 8'd100
            && powerState == stateBalanced && clockFrequencyLevel == 3'd3
            && voltageLevel == 3'd3 && !thermalThrottle && !emergencyActive
            && !powerGateALU && !powerGateBranchPredictor && !powerGateCache)
    else begin
        failCount++;
        $error("ERROR %0t reset values wrong: power %0d/80 temp %0d/100 state %s level %0d/3",
               $time, currentTotalPower, temperatureEstimate, powerState.name(),
               clockFrequencyLevel);
    end

    assert property (@(posedge clk) disable iff (!reset)
        sinceReset >= 4'd4 |-> int'(currentTotalPower) == expectedPower)
    else begin
        failCount++;
        $error("ERROR %0t currentTotalPower expected %0d actual %0d",
               $time, expectedPower, currentTotalPower);
    end

    assert property (@(posedge clk) disable iff (!reset)
        sinceReset >= 4'd1 |-> int'(temperatureEstimate) == expectedTemp)
    else begin
        failCount++;
        $error("ERROR %0t temperatureEstimate expected %0d actual %0d",
               $time, expectedTemp, temperatureEstimate);
    end

    assert property (@(posedge clk) disable iff (!reset)
        sinceReset >= 4'd1 |-> powerState == expectedState)
    else begin
        failCount++;
        $error("ERROR %0t powerState expected %s actual %s",
               $time, expectedState.name(), powerState.name());
    end

    assert property (@(posedge clk) disable iff (!reset)
        triggerAge == 5'd1 |-> thermalThrottle)
    else begin
        failCount++;
        $error("ERROR %0t thermalThrottle expected 1 actual 0 after a trigger", $time);
    end

    // Emergency holds for 15 cycles after the last trigger
    assert property (@(posedge clk) disable iff (!reset)
        triggerAge >= 5'd3 && triggerAge <= 5'd17 |-> powerState == stateCritical
            && clockFrequencyLevel == 3'd0 && powerGateBranchPredictor && powerGateCache)
    else begin
        failCount++;
        $error("ERROR %0t powerState/level/BP/cache expected CRITICAL/0/1/1 actual %s/%0d/%b/%b",
               $time, powerState.name(), clockFrequencyLevel, powerGateBranchPredictor,
               powerGateCache);
    end

    assert property (@(posedge clk) disable iff (!reset)
        voltageLevel == clockFrequencyLevel
        && (prevEmergency
            || (levelRise <= 1 && levelRise >= -1 && !(prevThrottle && levelRise > 0))))
    else begin
        failCount++;
        $error("ERROR %0t clockFrequencyLevel stepped from %0d to %0d, voltageLevel %0d",
               $time, prevLevel, clockFrequencyLevel, voltageLevel);
    end

    assert property (@(posedge clk) disable iff (!reset)
        computeHeld |-> !powerGateALU && !powerGateCache)
    else begin
        failCount++;
        $error("ERROR %0t compute gating expected ALU 0 cache 0 actual ALU %b cache %b",
               $time, powerGateALU, powerGateCache);
    end

endmodule

`default_nettype wire

//--- verif/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic reset
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Held low for the first 8 rising edges
    initial begin
        reset = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire
